// File: hw/wb_pkg.sv
package wb_pkg;

  // bus geometry
  localparam int data_width = 64;
  localparam int word_size  = 8;
  localparam int sel_width  = data_width / word_size;
  localparam int ram_size   = 4096;
  // word address, bytes folded into sel
  localparam int adr_width  = $clog2(ram_size / sel_width);

  typedef enum logic [2:0] {
    cti_classic = 3'b000,
    cti_const   = 3'b001,
    cti_incr    = 3'b010,
    cti_end     = 3'b111
  } wb_cti_e;

  typedef enum logic [1:0] {
    bte_linear = 2'b00,
    bte_wrap2  = 2'b01,
    bte_wrap4  = 2'b10,
    bte_wrap16 = 2'b11
  } wb_bte_e;

  typedef struct packed {
    logic [adr_width-1:0]  adr;
    logic [data_width-1:0] dat;
    logic                  cyc;
    logic                  stb;
    logic [sel_width-1:0]  sel;
    logic                  we;
    wb_cti_e               cti;
    wb_bte_e               bte;
  } wb_req_t;

  typedef struct packed {
    logic [data_width-1:0] dat;
    logic                  ack;
  } wb_rsp_t;

  // burst address rule, used by both ends of the bus
  function automatic logic [adr_width-1:0] next_adr(input logic [adr_width-1:0] adr,
                                                   input wb_cti_e cti,
                                                   input wb_bte_e bte);
    logic [adr_width-1:0] nxt;
    nxt = adr;
    if (cti != cti_const) begin
      case (bte)
        bte_wrap2:  nxt[0]   = ~adr[0];
        bte_wrap4:  nxt[1:0] = adr[1:0] + 2'd1;
        bte_wrap16: nxt[3:0] = adr[3:0] + 4'd1;
        default:    nxt      = adr + 1'b1;
      endcase
    end
    return nxt;
  endfunction

endpackage

// File: hw/mem_cmd_pkg.sv
package mem_cmd_pkg;

  localparam int max_beats = 16;
  // holds 1 to max_beats
  localparam int len_width = $clog2(max_beats + 1);

  typedef enum logic {
    op_read  = 1'b0,
    op_write = 1'b1
  } mem_op_e;

  typedef enum logic [1:0] {
    mode_single = 2'b00,
    mode_const  = 2'b01,
    mode_incr   = 2'b10
  } burst_mode_e;

  typedef struct packed {
    mem_op_e                      op;
    burst_mode_e                  mode;
    // wrap size, incr bursts only
    wb_pkg::wb_bte_e              bte;
    logic [wb_pkg::adr_width-1:0] adr;
    // same lanes on every beat
    logic [wb_pkg::sel_width-1:0] sel;
    logic [len_width-1:0]         len;
  } mem_cmd_t;

  typedef struct packed {
    logic [wb_pkg::data_width-1:0] dat;
    logic                          last;
  } rd_beat_t;

endpackage

// File: hw/wb_ram.sv
`timescale 1ns/1ps

module wb_ram (
  input  logic            clk_i,
  input  logic            reset_i,
  input  wb_pkg::wb_req_t wb_req_i,
  output wb_pkg::wb_rsp_t wb_rsp_o
);

  logic [wb_pkg::data_width-1:0] mem [0:(1 << wb_pkg::adr_width)-1];

  logic                         is_burst_r;
  logic                         is_burst_n;
  logic [wb_pkg::adr_width-1:0] adr_r;
  logic [wb_pkg::adr_width-1:0] adr_n;
  logic                         ack_r;
  logic                         ack_n;

  logic strobe;
  logic adr_ok;
  logic ack;
  logic burst_cti;
  logic burst_start;
  logic burst_stop;

  initial begin
    for (int i = 0; i < (1 << wb_pkg::adr_width); i++) begin
      mem[i] = '0;
    end
  end

  assign strobe = wb_req_i.cyc & wb_req_i.stb;

  // inside a burst the master must present the predicted address
  assign adr_ok = ~is_burst_r | (wb_req_i.adr == adr_r);
  assign ack    = strobe & ack_r & adr_ok;

  assign burst_cti   = (wb_req_i.cti == wb_pkg::cti_const) |
                       (wb_req_i.cti == wb_pkg::cti_incr);
  assign burst_start = strobe & ~is_burst_r & burst_cti;
  // end beat only counts once it is acked
  assign burst_stop  = ack & is_burst_r & (wb_req_i.cti == wb_pkg::cti_end);

  always_comb begin
    is_burst_n = is_burst_r;
    adr_n      = adr_r;
    ack_n      = ack_r;

    if (burst_start) begin
      is_burst_n = 1'b1;
    end else if (burst_stop) begin
      is_burst_n = 1'b0;
    end

    if (strobe) begin
      if (!is_burst_r) begin
        // classic or first burst beat, ack one cycle later
        adr_n = wb_req_i.adr;
        ack_n = ~ack_r;
      end else begin
        if (ack) begin
          adr_n = wb_pkg::next_adr(adr_r, wb_req_i.cti, wb_req_i.bte);
        end
        // ack held through the burst, dropped after end
        ack_n = ~burst_stop;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      is_burst_r <= 1'b0;
      adr_r      <= '0;
      ack_r      <= 1'b0;
    end else begin
      is_burst_r <= is_burst_n;
      adr_r      <= adr_n;
      ack_r      <= ack_n;
    end
  end

  // byte lane writes
  always @(posedge clk_i) begin
    if (strobe & adr_ok & wb_req_i.we) begin
      for (int b = 0; b < wb_pkg::sel_width; b++) begin
        if (wb_req_i.sel[b]) begin
          mem[wb_req_i.adr][b*wb_pkg::word_size +: wb_pkg::word_size] <=
            wb_req_i.dat[b*wb_pkg::word_size +: wb_pkg::word_size];
        end
      end
    end
  end

  // read data follows the registered address, valid alongside ack
  always_comb begin
    wb_rsp_o.dat = mem[adr_r];
    wb_rsp_o.ack = ack;
  end

endmodule

// File: hw/wb_burst_master.sv
`timescale 1ns/1ps

module wb_burst_master (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  mem_cmd_pkg::mem_cmd_t         cmd_i,
  input  logic                          cmd_valid_i,
  output logic                          cmd_ready_o,
  input  logic [wb_pkg::data_width-1:0] wdata_i,
  input  logic                          wdata_valid_i,
  output logic                          wdata_ready_o,
  output mem_cmd_pkg::rd_beat_t         rdata_o,
  output logic                          rdata_valid_o,
  output logic                          done_o,
  output wb_pkg::wb_req_t               wb_req_o,
  input  wb_pkg::wb_rsp_t               wb_rsp_i
);

  typedef enum logic [1:0] {
    st_idle,
    st_single,
    st_burst,
    st_restart
  } state_e;

  state_e                                state_r;
  state_e                                state_n;
  mem_cmd_pkg::mem_cmd_t                 cmd_r;
  logic [wb_pkg::adr_width-1:0]          adr_r;
  logic [mem_cmd_pkg::len_width-1:0]     beats_r;
  logic [wb_pkg::data_width-1:0]         wdat_r;
  logic                                  wdat_vld_r;
  logic                                  cmd_rdy_r;

  logic            is_write;
  logic            strobe;
  logic            last_beat;
  logic            beat_ack;
  logic            cmd_take;
  logic            wdat_take;
  wb_pkg::wb_cti_e cti;

  assign is_write  = (cmd_r.op == mem_cmd_pkg::op_write);
  // a write beat is only strobed once its data is held
  assign strobe    = ((state_r == st_single) | (state_r == st_burst)) &
                     (~is_write | wdat_vld_r);
  assign last_beat = (beats_r == mem_cmd_pkg::len_width'(1));
  assign beat_ack  = strobe & wb_rsp_i.ack;

  assign cmd_ready_o = cmd_rdy_r;
  assign cmd_take    = cmd_valid_i & cmd_rdy_r;

  // next beat can be loaded while the current one is acked
  assign wdata_ready_o = (state_r != st_idle) & is_write &
                         (~wdat_vld_r | (beat_ack & ~last_beat));
  assign wdat_take     = wdata_valid_i & wdata_ready_o;

  always_comb begin
    if (state_r == st_single) begin
      cti = wb_pkg::cti_classic;
    end else if (last_beat) begin
      cti = wb_pkg::cti_end;
    end else if (cmd_r.mode == mem_cmd_pkg::mode_const) begin
      cti = wb_pkg::cti_const;
    end else begin
      cti = wb_pkg::cti_incr;
    end
  end

  always_comb begin
    state_n = state_r;
    case (state_r)
      st_idle: begin
        if (cmd_take) begin
          if (cmd_i.mode == mem_cmd_pkg::mode_single) begin
            state_n = st_single;
          end else begin
            state_n = st_burst;
          end
        end
      end
      st_single: begin
        if (beat_ack) begin
          state_n = st_idle;
        end
      end
      st_burst: begin
        if (beat_ack) begin
          if (last_beat) begin
            state_n = st_idle;
          end else if (is_write & ~wdat_take) begin
            // write data ran dry, park with stb low
            state_n = st_restart;
          end
        end
      end
      st_restart: begin
        // resume the remaining beats from the current address
        if (wdat_take) begin
          state_n = st_burst;
        end
      end
      default: state_n = st_idle;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_r    <= st_idle;
      cmd_rdy_r  <= 1'b0;
      wdat_vld_r <= 1'b0;
      beats_r    <= '0;
    end else begin
      state_r   <= state_n;
      cmd_rdy_r <= (state_n == st_idle);
      if (cmd_take) begin
        beats_r <= (cmd_i.mode == mem_cmd_pkg::mode_single) ?
                   mem_cmd_pkg::len_width'(1) : cmd_i.len;
      end else if (beat_ack) begin
        beats_r <= beats_r - 1'b1;
      end
      if (wdat_take) begin
        wdat_vld_r <= 1'b1;
      end else if (beat_ack) begin
        wdat_vld_r <= 1'b0;
      end
    end
  end

  // command, address and write data
  always_ff @(posedge clk_i) begin
    if (cmd_take) begin
      cmd_r <= cmd_i;
      adr_r <= cmd_i.adr;
    end else if (beat_ack) begin
      adr_r <= wb_pkg::next_adr(adr_r, cti, cmd_r.bte);
    end
    if (wdat_take) begin
      wdat_r <= wdata_i;
    end
  end

  always_comb begin
    wb_req_o.adr = adr_r;
    wb_req_o.dat = wdat_r;
    wb_req_o.cyc = (state_r != st_idle);
    wb_req_o.stb = strobe;
    wb_req_o.sel = cmd_r.sel;
    wb_req_o.we  = is_write;
    wb_req_o.cti = cti;
    wb_req_o.bte = cmd_r.bte;
  end

  always_comb begin
    rdata_o.dat   = wb_rsp_i.dat;
    rdata_o.last  = last_beat;
    rdata_valid_o = beat_ack & ~is_write;
    done_o        = beat_ack & last_beat;
  end

endmodule

// File: hw/wb_mem_top.sv
`timescale 1ns/1ps

module wb_mem_top (
  input  logic                          clk_i,
  input  logic                          reset_i,
  input  mem_cmd_pkg::mem_cmd_t         cmd_i,
  input  logic                          cmd_valid_i,
  output logic                          cmd_ready_o,
  input  logic [wb_pkg::data_width-1:0] wdata_i,
  input  logic                          wdata_valid_i,
  output logic                          wdata_ready_o,
  output mem_cmd_pkg::rd_beat_t         rdata_o,
  output logic                          rdata_valid_o,
  output logic                          done_o
);

  // single master, single slave bus
  wb_pkg::wb_req_t wb_req;
  wb_pkg::wb_rsp_t wb_rsp;

  wb_burst_master master_i (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .cmd_i         (cmd_i),
    .cmd_valid_i   (cmd_valid_i),
    .cmd_ready_o   (cmd_ready_o),
    .wdata_i       (wdata_i),
    .wdata_valid_i (wdata_valid_i),
    .wdata_ready_o (wdata_ready_o),
    .rdata_o       (rdata_o),
    .rdata_valid_o (rdata_valid_o),
    .done_o        (done_o),
    .wb_req_o      (wb_req),
    .wb_rsp_i      (wb_rsp)
  );

  wb_ram ram_i (
    .clk_i    (clk_i),
    .reset_i  (reset_i),
    .wb_req_i (wb_req),
    .wb_rsp_o (wb_rsp)
  );

endmodule

// File: tests/wb_mem_props.sv
`timescale 1ns/1ps

module wb_mem_props (
  input logic            clk_i,
  input logic            reset_i,
  input wb_pkg::wb_req_t wb_req_i,
  input wb_pkg::wb_rsp_t wb_rsp_o
);

  logic strobe;
  logic strobe_seen_r;

  assign strobe = wb_req_i.cyc & wb_req_i.stb;

  // set by the first strobe after reset
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      strobe_seen_r <= 1'b0;
    end else if (strobe) begin
      strobe_seen_r <= 1'b1;
    end
  end

  ack_needs_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_rsp_o.ack |-> strobe)
    else $error("ack without cyc and stb");

  ack_drops_after_end: assert property (@(posedge clk_i) disable iff (reset_i)
    (wb_rsp_o.ack && strobe && wb_req_i.cti == wb_pkg::cti_end) |=> !wb_rsp_o.ack)
    else $error("ack still high after the end beat");

  stb_needs_cyc: assert property (@(posedge clk_i) disable iff (reset_i)
    wb_req_i.stb |-> wb_req_i.cyc)
    else $error("stb high without cyc");

  // the first strobe itself is not acked in its own cycle either
  quiet_until_strobe: assert property (@(posedge clk_i) disable iff (reset_i)
    !strobe_seen_r |-> !wb_rsp_o.ack)
    else $error("ack before the first strobe");

endmodule

bind wb_ram wb_mem_props props_i (.*);

// File: tests/wb_mem_tb.sv
`timescale 1ns/1ps

module wb_mem_tb;

  typedef logic [wb_pkg::adr_width-1:0]  adr_t;
  typedef logic [wb_pkg::data_width-1:0] dat_t;
  typedef logic [wb_pkg::sel_width-1:0]  sel_t;

  // beats per test, sizes the watchdog
  localparam int test_len [6] = '{8, 16, 60, 9, 12, 4};

  logic                  clk_i;
  logic                  reset_i;
  mem_cmd_pkg::mem_cmd_t cmd_i;
  logic                  cmd_valid_i;
  logic                  cmd_ready_o;
  dat_t                  wdata_i;
  logic                  wdata_valid_i;
  logic                  wdata_ready_o;
  mem_cmd_pkg::rd_beat_t rdata_o;
  logic                  rdata_valid_o;
  logic                  done_o;

  dat_t                  model [0:(1 << wb_pkg::adr_width)-1];
  dat_t                  wq [$];
  mem_cmd_pkg::rd_beat_t rd_q [$];
  logic [31:0]           lfsr = 32'hf806;
  int                    errors;
  int                    tests_run;
  int                    done_cnt;
  int                    early_activity;
  logic                  cmd_seen;

  wb_mem_top dut_i (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  initial begin
    int budget;
    budget = 0;
    foreach (test_len[i]) begin
      budget += test_len[i];
    end
    repeat (budget * 4 + 500) @(posedge clk_i);
    $display("watchdog expired, the tests did not finish in time");
    $display("*** TEST FAILED ***");
    $finish;
  end

  // no read data, done or write ready before the first command
  always @(negedge clk_i) begin
    if (!reset_i && !cmd_seen && (rdata_valid_o || done_o || wdata_ready_o)) begin
      early_activity++;
    end
  end

  // galois lfsr, one step per bit
  function automatic dat_t rand_bits(input int n);
    dat_t v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
      v = {v[wb_pkg::data_width-2:0], lfsr[0]};
    end
    return v;
  endfunction

  // address of the beat after a, by the burst rules
  function automatic adr_t step_adr(input adr_t a, input mem_cmd_pkg::burst_mode_e mode,
                                    input wb_pkg::wb_bte_e bte);
    int span;
    int base;
    if (mode == mem_cmd_pkg::mode_const) begin
      return a;
    end
    case (bte)
      wb_pkg::bte_wrap2:  span = 2;
      wb_pkg::bte_wrap4:  span = 4;
      wb_pkg::bte_wrap16: span = 16;
      default:            span = 1 << wb_pkg::adr_width;
    endcase
    base = (int'(a) / span) * span;
    return adr_t'(base + (int'(a) + 1) % span);
  endfunction

  function automatic mem_cmd_pkg::mem_cmd_t make_cmd(input mem_cmd_pkg::mem_op_e op,
      input mem_cmd_pkg::burst_mode_e mode, input wb_pkg::wb_bte_e bte, input adr_t adr,
      input sel_t sel, input int n);
    mem_cmd_pkg::mem_cmd_t c;
    c.op   = op;
    c.mode = mode;
    c.bte  = bte;
    c.adr  = adr;
    c.sel  = sel;
    c.len  = mem_cmd_pkg::len_width'(n);
    return c;
  endfunction

  task automatic check_beat(input mem_cmd_pkg::rd_beat_t got,
                            input mem_cmd_pkg::rd_beat_t exp, input string what);
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0t: %s got %h last %b, expected %h last %b", $time, what,
               got.dat, got.last, exp.dat, exp.last);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    if (got != exp) begin
      errors++;
      $display("[ERROR] %0t: %s count %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic fill_wq(input int n);
    wq.delete();
    repeat (n) wq.push_back(rand_bits(wb_pkg::data_width));
  endtask

  // issue one command, feed write data, collect read beats and done pulses
  task automatic run_cmd(input mem_cmd_pkg::mem_cmd_t c, input logic [15:0] stall_mask);
    int n;
    int idx;
    int hold;
    int cyc;
    int tail;
    logic [15:0] stalled;
    n = (c.mode == mem_cmd_pkg::mode_single) ? 1 : int'(c.len);
    idx = 0;
    hold = 0;
    cyc = 0;
    tail = 0;
    stalled = '0;
    done_cnt = 0;
    rd_q.delete();
    @(negedge clk_i);
    while (!cmd_ready_o && cyc < 50) begin
      @(negedge clk_i);
      cyc++;
    end
    if (!cmd_ready_o) begin
      errors++;
      $display("cmd_ready_o never rose, command not sent at %0t", $time);
      return;
    end
    cmd_i = c;
    cmd_valid_i = 1'b1;
    cmd_seen = 1'b1;
    @(negedge clk_i);
    cmd_valid_i = 1'b0;
    cyc = 0;
    while (tail < 2 && cyc < 20 * n + 40) begin
      if (done_cnt == 0 && cmd_ready_o) begin
        errors++;
        $display("cmd_ready_o high while a command is busy at %0t", $time);
      end
      if (rdata_valid_o) begin
        rd_q.push_back(rdata_o);
      end
      if (done_o) begin
        done_cnt++;
      end
      if (done_cnt > 0) begin
        tail++;
      end
      if (c.op == mem_cmd_pkg::op_write && idx < n) begin
        if (stall_mask[idx] && !stalled[idx]) begin
          stalled[idx] = 1'b1;
          hold = 3;
        end
        if (hold > 0) begin
          wdata_valid_i = 1'b0;
          hold--;
        end else begin
          wdata_valid_i = 1'b1;
          wdata_i = wq[idx];
          if (wdata_ready_o) begin
            idx++;
          end
        end
      end else begin
        wdata_valid_i = 1'b0;
      end
      @(negedge clk_i);
      cyc++;
    end
    wdata_valid_i = 1'b0;
    if (done_cnt == 0) begin
      errors++;
      $display("timeout, done_o never pulsed for the command at %0t", $time);
    end
  endtask

  task automatic write_cmd(input adr_t adr, input mem_cmd_pkg::burst_mode_e mode,
                           input wb_pkg::wb_bte_e bte, input sel_t sel, input int n,
                           input logic [15:0] stall_mask);
    adr_t a;
    run_cmd(make_cmd(mem_cmd_pkg::op_write, mode, bte, adr, sel, n), stall_mask);
    check_count(done_cnt, 1, "write done_o");
    a = adr;
    for (int i = 0; i < n; i++) begin
      for (int b = 0; b < wb_pkg::sel_width; b++) begin
        if (sel[b]) begin
          model[a][b*wb_pkg::word_size +: wb_pkg::word_size] =
            wq[i][b*wb_pkg::word_size +: wb_pkg::word_size];
        end
      end
      a = step_adr(a, mode, bte);
    end
  endtask

  task automatic read_cmd(input adr_t adr, input mem_cmd_pkg::burst_mode_e mode,
                          input wb_pkg::wb_bte_e bte, input int n, input string what);
    adr_t a;
    mem_cmd_pkg::rd_beat_t exp;
    run_cmd(make_cmd(mem_cmd_pkg::op_read, mode, bte, adr, '1, n), '0);
    check_count(done_cnt, 1, {what, " done_o"});
    check_count(rd_q.size(), n, {what, " beats"});
    a = adr;
    for (int i = 0; i < n && i < rd_q.size(); i++) begin
      exp.dat  = model[a];
      exp.last = (i == n - 1);
      check_beat(rd_q[i], exp, what);
      a = step_adr(a, mode, bte);
    end
  endtask

  task automatic finish_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("%s: ok", name);
    end else begin
      $display("%s: %0d errors", name, errors - err_before);
    end
  endtask

  task automatic single_rw_test;
    int e;
    adr_t adrs [4];
    e = errors;
    for (int i = 0; i < 4; i++) begin
      adrs[i] = adr_t'(rand_bits(wb_pkg::adr_width));
      fill_wq(1);
      write_cmd(adrs[i], mem_cmd_pkg::mode_single, wb_pkg::bte_linear,
                sel_t'(rand_bits(wb_pkg::sel_width)), 1, '0);
    end
    for (int i = 0; i < 4; i++) begin
      read_cmd(adrs[i], mem_cmd_pkg::mode_single, wb_pkg::bte_linear, 1, "single read");
    end
    finish_test("single write and read", e);
  endtask

  task automatic linear_burst_test;
    int e;
    adr_t a;
    e = errors;
    a = adr_t'(rand_bits(wb_pkg::adr_width));
    fill_wq(8);
    write_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_linear, '1, 8, '0);
    read_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_linear, 8, "linear read");
    finish_test("linear burst", e);
  endtask

  task automatic wrap_burst_test;
    int e;
    adr_t a;
    e = errors;
    a = adr_t'(rand_bits(wb_pkg::adr_width));
    a[1:0] = 2'd2;
    fill_wq(4);
    write_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_wrap4,
              sel_t'(rand_bits(wb_pkg::sel_width)), 4, '0);
    read_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_wrap4, 4, "wrap4 read");
    // whole aligned block in order, shows where each beat landed
    read_cmd(a & ~adr_t'(3), mem_cmd_pkg::mode_incr, wb_pkg::bte_linear, 4, "wrap4 block");
    a = adr_t'(rand_bits(wb_pkg::adr_width));
    a[3:0] = 4'd5;
    fill_wq(16);
    write_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_wrap16, '1, 16, '0);
    read_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_wrap16, 16, "wrap16 read");
    read_cmd(a & ~adr_t'(15), mem_cmd_pkg::mode_incr, wb_pkg::bte_linear, 16,
             "wrap16 block");
    finish_test("wrap bursts", e);
  endtask

  task automatic const_burst_test;
    int e;
    adr_t a;
    e = errors;
    a = adr_t'(rand_bits(wb_pkg::adr_width));
    fill_wq(5);
    write_cmd(a, mem_cmd_pkg::mode_const, wb_pkg::bte_linear, '1, 5, '0);
    read_cmd(a, mem_cmd_pkg::mode_const, wb_pkg::bte_linear, 4, "const read");
    finish_test("constant address burst", e);
  endtask

  task automatic stall_burst_test;
    int e;
    adr_t a;
    e = errors;
    a = adr_t'(rand_bits(wb_pkg::adr_width));
    fill_wq(6);
    // beats 0, 2 and 5 arrive late
    write_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_linear, '1, 6, 16'b0000_0000_0010_0101);
    read_cmd(a, mem_cmd_pkg::mode_incr, wb_pkg::bte_linear, 6, "stalled write readback");
    finish_test("write data stalls", e);
  endtask

  task automatic back_to_back_test;
    int e;
    adr_t a;
    e = errors;
    check_count(early_activity, 0, "outputs active before first command");
    a = adr_t'(rand_bits(wb_pkg::adr_width));
    fill_wq(1);
    write_cmd(a, mem_cmd_pkg::mode_single, wb_pkg::bte_linear, '1, 1, '0);
    read_cmd(a, mem_cmd_pkg::mode_single, wb_pkg::bte_linear, 1, "back to back read");
    read_cmd(a, mem_cmd_pkg::mode_const, wb_pkg::bte_linear, 2, "back to back const");
    finish_test("back to back commands", e);
  endtask

  initial begin
    cmd_i          = '0;
    cmd_valid_i    = 1'b0;
    wdata_i        = '0;
    wdata_valid_i  = 1'b0;
    reset_i        = 1'b1;
    errors         = 0;
    tests_run      = 0;
    done_cnt       = 0;
    early_activity = 0;
    cmd_seen       = 1'b0;
    foreach (model[i]) begin
      model[i] = '0;
    end
    repeat (10) @(negedge clk_i);
    reset_i = 1'b0;
    repeat (3) @(negedge clk_i);
    single_rw_test();
    linear_burst_test();
    wrap_burst_test();
    const_burst_test();
    stall_burst_test();
    back_to_back_test();
    $display("%0d tests run, %0d errors", tests_run, errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

// File: verilog.f
hw/wb_pkg.sv
hw/mem_cmd_pkg.sv
hw/wb_ram.sv
hw/wb_burst_master.sv
hw/wb_mem_top.sv
tests/wb_mem_props.sv
tests/wb_mem_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the wb_mem testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert -Wno-fatal --top-module wb_mem_tb -f verilog.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vwb_mem_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qF '*** TEST PASSED ***'; then
  exit 0
fi
exit 1
